/* bp_pkg.sv */
package bp_pkg;

    ////////////////////////////////
    // Widths
    ////////////////////////////////
    localparam int ADDR_W = 32;
    localparam int IDX_W  = 5;
    localparam int TAG_W  = 24;
    localparam int HIST_W = 10;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [IDX_W-1:0]  idx_t;
    typedef logic [TAG_W-1:0]  tag_t;

    // History in 9..8, counter n in bits 2n+1..2n
    typedef logic [HIST_W-1:0] hist_entry_t;

    // Slot 1 in 3..2, slot 2 in 1..0, each {history bit, taken}
    typedef logic [3:0] guess_t;

    // Fresh entry: history 0, every counter weakly not-taken
    localparam hist_entry_t HIST_INIT = 10'b00_0101_0101;

    ////////////////////////////////
    // Bundles
    ////////////////////////////////
    typedef struct packed {
        logic  vld;
        addr_t pc;
    } fetch_req_t;

    typedef struct packed {
        logic        exist;
        addr_t       target;
        logic        past_vld;
        hist_entry_t past;
    } slot_lookup_t;

    typedef struct packed {
        logic  branch;
        logic  reason;
        addr_t pc_new;
    } pred_t;

    typedef struct packed {
        logic  vld;
        addr_t pc;
        logic  taken;
        addr_t target;
        logic  mispredict;
    } resolve_t;

    typedef struct packed {
        logic        we;
        idx_t        idx;
        logic        slot;
        hist_entry_t entry;
    } ht_write_t;

    typedef struct packed {
        logic  we;
        idx_t  idx;
        logic  slot;
        tag_t  tag;
        addr_t target;
    } tt_write_t;

    ////////////////////////////////
    // APB register map
    ////////////////////////////////
    localparam logic [31:0] REG_CTRL    = 32'h0;
    localparam logic [31:0] REG_LOOKUPS = 32'h4;
    localparam logic [31:0] REG_MISPRED = 32'h8;

    // Two-bit counter picked by a history value
    function automatic logic [1:0] ctr_get(hist_entry_t e, logic [1:0] h);
        return e[{h, 1'b0} +: 2];
    endfunction

endpackage

/* bp_slot_ram.sv */
`timescale 1ns/1ps

module bp_slot_ram #(
    parameter int IDX_W = bp_pkg::IDX_W
) (
    input  logic           clk,
    input  logic           we,
    input  bp_pkg::idx_t   waddr,
    input  bp_pkg::guess_t wdata,
    input  bp_pkg::idx_t   raddr,
    output bp_pkg::guess_t rdata
);
    import bp_pkg::*;

    guess_t mem [2**IDX_W];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // Read is combinational, same cycle as the fetch
    assign rdata = mem[raddr];

endmodule

/* bp_target_table.sv */
`timescale 1ns/1ps

module bp_target_table #(
    parameter int ADDR_W = bp_pkg::ADDR_W,
    parameter int IDX_W  = bp_pkg::IDX_W,
    parameter int TAG_W  = bp_pkg::TAG_W
) (
    input  logic                 clk,
    input  logic                 rstn,
    input  bp_pkg::addr_t        fetch_pc,
    input  bp_pkg::tt_write_t    wr,
    output bp_pkg::slot_lookup_t slot1,
    output bp_pkg::slot_lookup_t slot2
);
    import bp_pkg::*;

    localparam int SETS = 2**IDX_W;

    // One way per slot in every set
    tag_t  tag_mem [SETS][2];
    addr_t tgt_mem [SETS][2];
    logic [1:0][SETS-1:0] valid;

    idx_t fidx;
    tag_t ftag;

    assign fidx = fetch_pc[IDX_W+2:3];
    assign ftag = fetch_pc[ADDR_W-1 -: TAG_W];

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid <= '0;
        end else if (wr.we) begin
            valid[wr.slot][wr.idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr.we) begin
            tag_mem[wr.idx][wr.slot] <= wr.tag;
            tgt_mem[wr.idx][wr.slot] <= wr.target;
        end
    end

    ////////////////////////////////
    // Lookup
    ////////////////////////////////
    // History fields come from the history table
    always_comb begin
        slot1        = '0;
        slot1.exist  = valid[0][fidx] && (tag_mem[fidx][0] == ftag);
        slot1.target = tgt_mem[fidx][0];

        slot2        = '0;
        slot2.exist  = valid[1][fidx] && (tag_mem[fidx][1] == ftag);
        slot2.target = tgt_mem[fidx][1];
    end

endmodule

/* bp_history_table.sv */
`timescale 1ns/1ps

module bp_history_table #(
    parameter int IDX_W = bp_pkg::IDX_W
) (
    input  logic                clk,
    input  logic                rstn,
    input  bp_pkg::addr_t       fetch_pc,
    input  bp_pkg::addr_t       res_pc,
    output bp_pkg::hist_entry_t res_entry,
    output logic                res_entry_vld,
    input  bp_pkg::ht_write_t   wr,
    output bp_pkg::hist_entry_t past1,
    output logic                past_vld1,
    output bp_pkg::hist_entry_t past2,
    output logic                past_vld2
);
    import bp_pkg::*;

    localparam int SETS = 2**IDX_W;

    hist_entry_t ent_mem [SETS][2];
    logic [1:0][SETS-1:0] valid;

    idx_t fidx;
    idx_t ridx;
    logic rslot;

    assign fidx  = fetch_pc[IDX_W+2:3];
    assign ridx  = res_pc[IDX_W+2:3];
    // Upper word of the pair is slot 2
    assign rslot = res_pc[2];

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid <= '0;
        end else if (wr.we) begin
            valid[wr.slot][wr.idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr.we) begin
            ent_mem[wr.idx][wr.slot] <= wr.entry;
        end
    end

    ////////////////////////////////
    // Fetch read port
    ////////////////////////////////
    assign past1     = ent_mem[fidx][0];
    assign past_vld1 = valid[0][fidx];
    assign past2     = ent_mem[fidx][1];
    assign past_vld2 = valid[1][fidx];

    ////////////////////////////////
    // Resolve read port
    ////////////////////////////////
    assign res_entry     = ent_mem[ridx][rslot];
    assign res_entry_vld = valid[rslot][ridx];

endmodule

/* bp_predict_unit.sv */
`timescale 1ns/1ps

module bp_predict_unit #(
    parameter int ADDR_W = bp_pkg::ADDR_W,
    parameter int IDX_W  = bp_pkg::IDX_W
) (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 en,
    input  bp_pkg::fetch_req_t   fetch,
    input  bp_pkg::slot_lookup_t slot1,
    input  bp_pkg::slot_lookup_t slot2,
    input  bp_pkg::hist_entry_t  past1,
    input  bp_pkg::hist_entry_t  past2,
    input  logic                 past_vld1,
    input  logic                 past_vld2,
    input  bp_pkg::resolve_t     resolve,
    output bp_pkg::pred_t        pred
);
    import bp_pkg::*;

    localparam int SETS = 2**IDX_W;

    idx_t         fidx;
    idx_t         ridx;
    guess_t       g_rd;
    guess_t       g_wr;
    logic         g_we;
    slot_lookup_t lk1;
    slot_lookup_t lk2;
    logic [1:0]   h1;
    logic [1:0]   h2;
    logic         t1;
    logic         t2;
    logic         fl1_new;
    logic         fl2_new;
    logic         flush;

    // Set while a slot still has an unresolved guess
    logic [SETS-1:0] gflag1;
    logic [SETS-1:0] gflag2;

    function automatic logic slot_dir(slot_lookup_t lk, logic [1:0] h, logic back);
        logic [1:0] ctr;
        ctr = ctr_get(lk.past, h);
        if (!lk.exist) begin
            return 1'b0;
        end else if (lk.past_vld) begin
            return ctr[1];
        end
        // No history yet, so assume loops go backward
        return back;
    endfunction

    assign fidx  = fetch.pc[IDX_W+2:3];
    assign ridx  = resolve.pc[IDX_W+2:3];
    assign flush = resolve.vld & resolve.mispredict;

    // Merge target and history lookups per slot
    assign lk1 = '{exist: slot1.exist, target: slot1.target, past_vld: past_vld1, past: past1};
    assign lk2 = '{exist: slot2.exist, target: slot2.target, past_vld: past_vld2, past: past2};

    ////////////////////////////////
    // Direction per slot
    ////////////////////////////////
    assign h1 = gflag1[fidx] ? g_rd[3:2] : lk1.past[9:8];
    assign h2 = gflag2[fidx] ? g_rd[1:0] : lk2.past[9:8];

    // Slot 1 drops out when fetch starts at the upper word
    assign t1 = ~fetch.pc[2] & slot_dir(lk1, h1, lk1.target < fetch.pc);
    assign t2 = slot_dir(lk2, h2, lk2.target < fetch.pc);

    ////////////////////////////////
    // Guess log
    ////////////////////////////////
    assign fl1_new = ~fetch.pc[2] & lk1.exist & lk1.past_vld;
    assign fl2_new = ~t1 & lk2.exist & lk2.past_vld;
    assign g_wr    = {h1[0], t1, h2[0], t2};
    assign g_we    = fetch.vld & en;

    bp_slot_ram #(
        .IDX_W (IDX_W)
    ) guess_ram_i (
        .clk   (clk),
        .we    (g_we),
        .waddr (fidx),
        .wdata (g_wr),
        .raddr (fidx),
        .rdata (g_rd)
    );

    // Later assignments win: resolve over fetch, flush over all
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            gflag1 <= '0;
            gflag2 <= '0;
        end else begin
            if (g_we) begin
                gflag1[fidx] <= fl1_new;
                gflag2[fidx] <= fl2_new;
            end
            if (resolve.vld) begin
                if (resolve.pc[2]) begin
                    gflag2[ridx] <= 1'b0;
                end else begin
                    gflag1[ridx] <= 1'b0;
                end
            end
            if (flush) begin
                gflag1 <= '0;
                gflag2 <= '0;
            end
        end
    end

    ////////////////////////////////
    // Next pc
    ////////////////////////////////
    always_comb begin
        pred.branch = fetch.vld & (t1 | t2);
        pred.reason = fetch.pc[2] | (~t1 & t2);
        if (t1) begin
            pred.pc_new = lk1.target;
        end else if (t2) begin
            pred.pc_new = lk2.target;
        end else begin
            pred.pc_new = {fetch.pc[ADDR_W-1:3] + 1'b1, 3'b000};
        end
    end

endmodule

/* bp_resolve_unit.sv */
`timescale 1ns/1ps

module bp_resolve_unit #(
    parameter int ADDR_W = bp_pkg::ADDR_W,
    parameter int IDX_W  = bp_pkg::IDX_W,
    parameter int TAG_W  = bp_pkg::TAG_W
) (
    input  bp_pkg::resolve_t    resolve,
    input  bp_pkg::hist_entry_t res_entry,
    input  logic                res_entry_vld,
    output bp_pkg::ht_write_t   ht_wr,
    output bp_pkg::tt_write_t   tt_wr
);
    import bp_pkg::*;

    hist_entry_t base;
    hist_entry_t trained;
    logic [1:0]  hist;
    logic [1:0]  ctr;
    logic [1:0]  ctr_new;

    ////////////////////////////////
    // Counter and history training
    ////////////////////////////////
    always_comb begin
        base = res_entry_vld ? res_entry : HIST_INIT;
        hist = base[9:8];
        ctr  = ctr_get(base, hist);

        // Saturate at 0 and 3
        if (resolve.taken) begin
            ctr_new = (ctr == 2'd3) ? ctr : ctr + 2'd1;
        end else begin
            ctr_new = (ctr == 2'd0) ? ctr : ctr - 2'd1;
        end

        trained                    = base;
        trained[{hist, 1'b0} +: 2] = ctr_new;
        // Shift the outcome into the history
        trained[9:8]               = {hist[0], resolve.taken};
    end

    assign ht_wr.we    = resolve.vld;
    assign ht_wr.idx   = resolve.pc[IDX_W+2:3];
    assign ht_wr.slot  = resolve.pc[2];
    assign ht_wr.entry = trained;

    // Targets only matter for taken branches
    assign tt_wr.we     = resolve.vld & resolve.taken;
    assign tt_wr.idx    = resolve.pc[IDX_W+2:3];
    assign tt_wr.slot   = resolve.pc[2];
    assign tt_wr.tag    = resolve.pc[ADDR_W-1 -: TAG_W];
    assign tt_wr.target = resolve.target;

endmodule

/* bp_apb_regs.sv */
`timescale 1ns/1ps

module bp_apb_regs (
    input  logic        clk,
    input  logic        rstn,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    input  logic        fetch_vld,
    input  logic        mispredict,
    output logic        en
);
    import bp_pkg::*;

    logic        access;
    logic        wr_acc;
    logic        sel_ctrl;
    logic        sel_look;
    logic        sel_mis;
    logic [31:0] lookups;
    logic [31:0] mispred;

    assign sel_ctrl = (paddr == REG_CTRL);
    assign sel_look = (paddr == REG_LOOKUPS);
    assign sel_mis  = (paddr == REG_MISPRED);

    // No wait states
    assign access  = psel & penable;
    assign wr_acc  = access & pwrite;
    assign pready  = access;
    assign pslverr = access & ~(sel_ctrl | sel_look | sel_mis);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            en <= 1'b1;
        end else if (wr_acc && sel_ctrl) begin
            en <= pwdata[0];
        end
    end

    ////////////////////////////////
    // Statistics counters
    ////////////////////////////////
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            lookups <= '0;
            mispred <= '0;
        end else begin
            if (wr_acc && sel_look) begin
                lookups <= '0;
            end else if (fetch_vld && lookups != '1) begin
                lookups <= lookups + 32'd1;
            end
            if (wr_acc && sel_mis) begin
                mispred <= '0;
            end else if (mispredict && mispred != '1) begin
                mispred <= mispred + 32'd1;
            end
        end
    end

    always_comb begin
        prdata = '0;
        if (sel_ctrl) begin
            prdata = {31'd0, en};
        end else if (sel_look) begin
            prdata = lookups;
        end else if (sel_mis) begin
            prdata = mispred;
        end
    end

endmodule

/* branch_predictor_top.sv */
`timescale 1ns/1ps

module branch_predictor_top #(
    parameter int ADDR_W = bp_pkg::ADDR_W,
    parameter int IDX_W  = bp_pkg::IDX_W,
    parameter int TAG_W  = bp_pkg::TAG_W
) (
    input  logic               clk,
    input  logic               rstn,
    input  bp_pkg::fetch_req_t fetch,
    output bp_pkg::pred_t      pred,
    input  bp_pkg::resolve_t   resolve,
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  logic [31:0]        paddr,
    input  logic [31:0]        pwdata,
    output logic [31:0]        prdata,
    output logic               pready,
    output logic               pslverr
);
    import bp_pkg::*;

    slot_lookup_t slot1;
    slot_lookup_t slot2;
    hist_entry_t  past1;
    hist_entry_t  past2;
    hist_entry_t  res_entry;
    logic         past_vld1;
    logic         past_vld2;
    logic         res_entry_vld;
    logic         en;
    ht_write_t    ht_wr;
    tt_write_t    tt_wr;

    ////////////////////////////////
    // Lookup (decode)
    ////////////////////////////////
    bp_target_table #(
        .ADDR_W (ADDR_W),
        .IDX_W  (IDX_W),
        .TAG_W  (TAG_W)
    ) target_table_i (
        .clk      (clk),
        .rstn     (rstn),
        .fetch_pc (fetch.pc),
        .wr       (tt_wr),
        .slot1    (slot1),
        .slot2    (slot2)
    );

    bp_history_table #(
        .IDX_W (IDX_W)
    ) history_table_i (
        .clk           (clk),
        .rstn          (rstn),
        .fetch_pc      (fetch.pc),
        .res_pc        (resolve.pc),
        .res_entry     (res_entry),
        .res_entry_vld (res_entry_vld),
        .wr            (ht_wr),
        .past1         (past1),
        .past_vld1     (past_vld1),
        .past2         (past2),
        .past_vld2     (past_vld2)
    );

    ////////////////////////////////
    // Prediction (execute)
    ////////////////////////////////
    bp_predict_unit #(
        .ADDR_W (ADDR_W),
        .IDX_W  (IDX_W)
    ) predict_unit_i (
        .clk       (clk),
        .rstn      (rstn),
        .en        (en),
        .fetch     (fetch),
        .slot1     (slot1),
        .slot2     (slot2),
        .past1     (past1),
        .past2     (past2),
        .past_vld1 (past_vld1),
        .past_vld2 (past_vld2),
        .resolve   (resolve),
        .pred      (pred)
    );

    ////////////////////////////////
    // Training (result)
    ////////////////////////////////
    bp_resolve_unit #(
        .ADDR_W (ADDR_W),
        .IDX_W  (IDX_W),
        .TAG_W  (TAG_W)
    ) resolve_unit_i (
        .resolve       (resolve),
        .res_entry     (res_entry),
        .res_entry_vld (res_entry_vld),
        .ht_wr         (ht_wr),
        .tt_wr         (tt_wr)
    );

    bp_apb_regs apb_regs_i (
        .clk        (clk),
        .rstn       (rstn),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .fetch_vld  (fetch.vld),
        .mispredict (resolve.vld & resolve.mispredict),
        .en         (en)
    );

endmodule

/* tb_branch_predictor.sv */
`timescale 1ns/1ps

module tb_branch_predictor;
    import bp_pkg::*;

    localparam int APB_TIMEOUT = 20;
    localparam int SETS        = 32;

    logic        clk;
    logic        rstn;
    fetch_req_t  fetch;
    pred_t       pred;
    resolve_t    resolve;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    integer      seed;
    int          pred_errors;
    int          reg_errors;
    addr_t       pool [16];

    ////////////////////////////////
    // Reference model state
    ////////////////////////////////
    logic        m_tt_vld [SETS][2];
    tag_t        m_tt_tag [SETS][2];
    addr_t       m_tt_tgt [SETS][2];
    logic        m_ht_vld [SETS][2];
    logic [1:0]  m_hist   [SETS][2];
    logic [1:0]  m_ctr    [SETS][2][4];
    logic        m_gflag  [SETS][2];
    logic [1:0]  m_ghist  [SETS][2];
    logic        m_en;
    int          n_fetch;
    int          n_mis;

    // Per-slot results of the latest model lookup
    logic        p_hit [2];
    logic        p_t   [2];
    logic [1:0]  p_h   [2];

    branch_predictor_top #(
        .ADDR_W (ADDR_W),
        .IDX_W  (IDX_W),
        .TAG_W  (TAG_W)
    ) dut_i (
        .clk     (clk),
        .rstn    (rstn),
        .fetch   (fetch),
        .pred    (pred),
        .resolve (resolve),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Expected prediction for a fetch pc from the model tables
    task automatic predict_fetch(input addr_t pc, output pred_t p);
        int   idx;
        int   s;
        logic hit;
        idx = int'(pc[7:3]);
        for (s = 0; s < 2; s++) begin
            hit      = m_tt_vld[idx][s] && (m_tt_tag[idx][s] == pc[31:8]);
            p_hit[s] = hit;
            p_h[s]   = m_gflag[idx][s] ? m_ghist[idx][s] : m_hist[idx][s];
            if (!hit) begin
                p_t[s] = 1'b0;
            end else if (m_ht_vld[idx][s]) begin
                p_t[s] = m_ctr[idx][s][p_h[s]][1];
            end else begin
                p_t[s] = (m_tt_tgt[idx][s] < pc);
            end
        end
        // Lower word lies before the fetch start
        if (pc[2]) begin
            p_t[0] = 1'b0;
        end
        p.branch = p_t[0] | p_t[1];
        p.reason = pc[2] | (!p_t[0] & p_t[1]);
        if (p_t[0]) begin
            p.pc_new = m_tt_tgt[idx][0];
        end else if (p_t[1]) begin
            p.pc_new = m_tt_tgt[idx][1];
        end else begin
            p.pc_new = (pc & ~32'h7) + 32'd8;
        end
    endtask

    // Apply the inputs sampled at this edge to the model
    task automatic update_model();
        pred_t      p;
        int         fi;
        int         ri;
        int         rs;
        int         s;
        int         k;
        logic [1:0] h;
        logic [1:0] c;
        predict_fetch(fetch.pc, p);
        fi = int'(fetch.pc[7:3]);
        ri = int'(resolve.pc[7:3]);
        rs = int'(resolve.pc[2]);
        if (fetch.vld) begin
            n_fetch++;
        end
        if (resolve.vld && resolve.mispredict) begin
            n_mis++;
        end
        // Guessed history is the used history shifted by the guess
        if (fetch.vld && m_en) begin
            for (s = 0; s < 2; s++) begin
                m_ghist[fi][s] = {p_h[s][0], p_t[s]};
            end
            m_gflag[fi][0] = !fetch.pc[2] && p_hit[0] && m_ht_vld[fi][0];
            m_gflag[fi][1] = !p_t[0] && p_hit[1] && m_ht_vld[fi][1];
        end
        if (resolve.vld) begin
            m_gflag[ri][rs] = 1'b0;
        end
        if (resolve.vld && resolve.mispredict) begin
            for (k = 0; k < SETS; k++) begin
                m_gflag[k][0] = 1'b0;
                m_gflag[k][1] = 1'b0;
            end
        end
        if (resolve.vld) begin
            if (!m_ht_vld[ri][rs]) begin
                m_ht_vld[ri][rs] = 1'b1;
                m_hist[ri][rs]   = 2'd0;
                for (k = 0; k < 4; k++) begin
                    m_ctr[ri][rs][k] = 2'd1;
                end
            end
            h = m_hist[ri][rs];
            c = m_ctr[ri][rs][h];
            if (resolve.taken && c != 2'd3) begin
                c = c + 2'd1;
            end else if (!resolve.taken && c != 2'd0) begin
                c = c - 2'd1;
            end
            m_ctr[ri][rs][h] = c;
            m_hist[ri][rs]   = {h[0], resolve.taken};
            if (resolve.taken) begin
                m_tt_vld[ri][rs] = 1'b1;
                m_tt_tag[ri][rs] = resolve.pc[31:8];
                m_tt_tgt[ri][rs] = resolve.target;
            end
        end
    endtask

    task automatic tick();
        @(posedge clk);
        update_model();
    endtask

    task automatic report_counts();
        $display("Errors: %0d prediction, %0d register", pred_errors, reg_errors);
    endtask

    ////////////////////////////////
    // Fetch and resolve traffic
    ////////////////////////////////
    task automatic run_cycle(input fetch_req_t f, input resolve_t r);
        pred_t exp;
        tick();
        fetch   <= f;
        resolve <= r;
        @(negedge clk);
        predict_fetch(fetch.pc, exp);
        if (fetch.vld) begin
            assert (pred == exp) else begin
                pred_errors++;
                $display("MISMATCH at %0t: pc %h gave branch %0b reason %0b pc_new %h",
                         $time, fetch.pc, pred.branch, pred.reason, pred.pc_new);
                $display("    expected branch %0b reason %0b pc_new %h",
                         exp.branch, exp.reason, exp.pc_new);
            end
        end else begin
            assert (!pred.branch) else begin
                pred_errors++;
                $display("MISMATCH at %0t: branch set without a fetch", $time);
            end
        end
    endtask

    task automatic random_cycles(input int count, input logic with_resolve);
        fetch_req_t  f;
        resolve_t    r;
        addr_t       last_pc;
        logic [31:0] rnd;
        int          i;
        last_pc = pool[0];
        for (i = 0; i < count; i++) begin
            rnd   = $random(seed);
            f.vld = (rnd[2:0] != 3'd0);
            // Repeat the pair often so guesses pile up
            f.pc    = rnd[3] ? last_pc : pool[rnd[7:4]];
            last_pc = f.pc;
            r.vld        = with_resolve && (rnd[10:8] < 3'd3);
            r.taken      = rnd[11] | rnd[12];
            r.mispredict = (rnd[15:13] == 3'd0);
            r.pc         = pool[rnd[19:16]];
            r.target     = pool[rnd[23:20]];
            run_cycle(f, r);
        end
    endtask

    ////////////////////////////////
    // APB access
    ////////////////////////////////
    task automatic apb_xfer(input logic wr, input logic [31:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
        int waits;
        tick();
        fetch   <= '0;
        resolve <= '0;
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= wdata;
        tick();
        penable <= 1'b1;
        @(negedge clk);
        waits = 0;
        while (!pready && waits < APB_TIMEOUT) begin
            @(negedge clk);
            waits++;
        end
        if (!pready) begin
            $display("Timeout: no pready for the APB access to %h", addr);
            report_counts();
            $display("=== FAIL ===");
            $finish;
        end else begin
            rdata = prdata;
            err   = pslverr;
            tick();
            psel    <= 1'b0;
            penable <= 1'b0;
        end
    endtask

    task automatic reg_write(input logic [31:0] addr, input logic [31:0] data);
        logic [31:0] rdata;
        logic        err;
        apb_xfer(1'b1, addr, data, rdata, err);
        assert (!err) else begin
            reg_errors++;
            $display("MISMATCH at %0t: pslverr on write to %h", $time, addr);
        end
        if (addr == REG_CTRL) begin
            m_en = data[0];
        end else if (addr == REG_LOOKUPS) begin
            n_fetch = 0;
        end else if (addr == REG_MISPRED) begin
            n_mis = 0;
        end
    endtask

    task automatic check_read(input logic [31:0] addr, input logic exp_err);
        logic [31:0] rdata;
        logic [31:0] exp;
        logic        err;
        apb_xfer(1'b0, addr, 32'd0, rdata, err);
        exp = 32'd0;
        if (addr == REG_CTRL) begin
            exp = {31'd0, m_en};
        end else if (addr == REG_LOOKUPS) begin
            exp = 32'(n_fetch);
        end else if (addr == REG_MISPRED) begin
            exp = 32'(n_mis);
        end
        assert (err == exp_err) else begin
            reg_errors++;
            $display("MISMATCH at %0t: pslverr %0b at %h, expected %0b",
                     $time, err, addr, exp_err);
        end
        if (!exp_err) begin
            assert (rdata == exp) else begin
                reg_errors++;
                $display("MISMATCH at %0t: read %h from %h, expected %h",
                         $time, rdata, addr, exp);
            end
        end
    endtask

    ////////////////////////////////
    // Main sequence
    ////////////////////////////////
    initial begin
        int i;
        int s;
        int k;
        seed        = 32'h5c43;
        rstn        = 1'b0;
        fetch       = '0;
        resolve     = '0;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = 32'd0;
        pwdata      = 32'd0;
        pred_errors = 0;
        reg_errors  = 0;
        n_fetch     = 0;
        n_mis       = 0;
        m_en        = 1'b1;
        for (i = 0; i < SETS; i++) begin
            for (s = 0; s < 2; s++) begin
                m_tt_vld[i][s] = 1'b0;
                m_tt_tag[i][s] = '0;
                m_tt_tgt[i][s] = '0;
                m_ht_vld[i][s] = 1'b0;
                m_hist[i][s]   = 2'd0;
                m_gflag[i][s]  = 1'b0;
                m_ghist[i][s]  = 2'd0;
                for (k = 0; k < 4; k++) begin
                    m_ctr[i][s][k] = 2'd1;
                end
            end
        end
        // Two tags over four sets and both slots, so entries collide
        for (i = 0; i < 16; i++) begin
            pool[i] = {(i < 8) ? 24'h000010 : 24'h0000a3, 5'(3 * ((i / 2) % 4) + 1),
                       (i % 2) == 1, 2'b00};
        end

        repeat (5) @(posedge clk);
        rstn <= 1'b1;
        @(negedge clk);
        assert (!pred.branch && !pready && !pslverr) else begin
            pred_errors++;
            $display("MISMATCH at %0t: outputs active after reset", $time);
        end

        // Empty tables first
        random_cycles(40, 1'b0);
        random_cycles(1500, 1'b1);
        check_read(REG_LOOKUPS, 1'b0);
        check_read(REG_MISPRED, 1'b0);

        // Guess log frozen while disabled
        reg_write(REG_CTRL, 32'd0);
        check_read(REG_CTRL, 1'b0);
        random_cycles(400, 1'b1);
        check_read(REG_LOOKUPS, 1'b0);
        check_read(REG_MISPRED, 1'b0);
        reg_write(REG_LOOKUPS, 32'd0);
        check_read(REG_LOOKUPS, 1'b0);

        reg_write(REG_CTRL, 32'd1);
        check_read(REG_CTRL, 1'b0);
        random_cycles(800, 1'b1);
        reg_write(REG_MISPRED, 32'd0);
        random_cycles(200, 1'b1);
        check_read(REG_LOOKUPS, 1'b0);
        check_read(REG_MISPRED, 1'b0);
        check_read(32'hc, 1'b1);

        report_counts();
        if (pred_errors + reg_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* branch_predictor.f */
bp_pkg.sv
bp_slot_ram.sv
bp_target_table.sv
bp_history_table.sv
bp_predict_unit.sv
bp_resolve_unit.sv
bp_apb_regs.sv
branch_predictor_top.sv
tb_branch_predictor.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and scan the log for failure

cd "$(dirname "$0")" || exit 1

LOG=sim.log
FAIL_MSG="=== FAIL ==="

verilator --binary --assert -Wno-fatal \
    --top-module tb_branch_predictor \
    -f branch_predictor.f -o tb_branch_predictor \
    > build.log 2>&1 \
    || { cat build.log; echo "Verilator build failed"; exit 1; }

./obj_dir/tb_branch_predictor > "$LOG" 2>&1 \
    || { cat "$LOG"; echo "Simulation exited with an error"; exit 1; }

cat "$LOG"
grep -qF "$FAIL_MSG" "$LOG" && { echo "Simulation failed"; exit 1; }
echo "Simulation passed"
